/* all.f */
hdl/gpio_pkg.sv
hdl/axil_write_stage.sv
hdl/axil_read_stage.sv
hdl/gpio_input_sync.sv
hdl/gpio_regs.sv
hdl/gpio_irq.sv
hdl/axi_gpio_top.sv
tb/tb_axi_gpio.sv

/* hdl/axi_gpio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_gpio_top import gpio_pkg::*; (
    input  wire         aclk,
    input  wire         rst,
    input  wire waddr_t awaddr,
    input  wire [2:0]   awprot,
    input  wire         awvalid,
    output logic        awready,
    input  wire word_t  wdata,
    input  wire strb_t  wstrb,
    input  wire         wvalid,
    output logic        wready,
    output resp_t       bresp,
    output logic        bvalid,
    input  wire         bready,
    input  wire waddr_t araddr,
    input  wire [2:0]   arprot,
    input  wire         arvalid,
    output logic        arready,
    output word_t       rdata,
    output resp_t       rresp,
    output logic        rvalid,
    input  wire         rready,
    input  wire gpio_t  gpio_io_i,
    output gpio_t       gpio_io_o,
    output gpio_t       gpio_io_t,
    input  wire gpio_t  gpio2_io_i,
    output gpio_t       gpio2_io_o,
    output gpio_t       gpio2_io_t,
    output logic        irq
);

    logic      wr_en;    // Write strobe from bus stage
    waddr_t    wr_addr;
    word_t     wr_data;
    strb_t     wr_strb;
    waddr_t    rd_addr;
    word_t     rd_data;
    gpio_t     in1_sync; // Synchronized pins
    gpio_t     in2_sync;
    irq_bits_t chg;
    logic      gier;
    irq_bits_t ier;
    irq_bits_t isr;

    axil_write_stage u_wr (
        .aclk, .rst, .awaddr, .awprot, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready, .bresp, .bvalid, .bready,
        .wr_en, .wr_addr, .wr_data, .wr_strb
    );

    axil_read_stage u_rd (
        .aclk, .rst, .araddr, .arprot, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready, .rd_addr, .rd_data
    );

    gpio_input_sync u_sync (
        .aclk, .rst, .gpio_io_i, .gpio2_io_i, .in1_sync, .in2_sync, .chg
    );

    gpio_regs u_regs (
        .aclk, .rst, .wr_en, .wr_addr, .wr_data, .wr_strb, .rd_addr,
        .in1_sync, .in2_sync, .isr, .gpio_io_o, .gpio_io_t,
        .gpio2_io_o, .gpio2_io_t, .gier, .ier, .rd_data
    );

    gpio_irq u_irq (
        .aclk, .rst, .wr_en, .wr_addr, .wr_data, .wr_strb,
        .chg, .gier, .ier, .isr, .irq
    );

endmodule

`default_nettype wire

/* hdl/axil_read_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_read_stage import gpio_pkg::*; (
    input  wire         aclk,
    input  wire         rst,
    input  wire waddr_t araddr,
    input  wire [2:0]   arprot,  // Accepted, not decoded
    input  wire         arvalid,
    output logic        arready,
    output word_t       rdata,
    output resp_t       rresp,
    output logic        rvalid,
    input  wire         rready,
    output waddr_t      rd_addr, // To register read mux
    input  wire word_t  rd_data  // Combinational from gpio_regs
);

    rd_state_t state_q;
    word_t     rdata_q; // Captured read word
    logic      accept;

    assign accept  = (state_q == RD_IDLE) && arvalid;
    assign arready = accept;
    assign rd_addr = araddr;     // Mux sees the address in the accept cycle

    assign rvalid = (state_q == RD_DATA);
    assign rdata  = rdata_q;
    assign rresp  = RESP_OKAY;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state_q <= RD_IDLE;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    if (accept) begin
                        state_q <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (rready) begin
                        state_q <= RD_IDLE; // Data taken
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            rdata_q <= rd_data; // Snapshot of registers and pins
        end
    end

    // Stalled read data must not move
    a_rdata_stable: assert property (@(posedge aclk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rdata changed while stalled");

endmodule

`default_nettype wire

/* hdl/axil_write_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_write_stage import gpio_pkg::*; (
    input  wire         aclk,
    input  wire         rst,
    input  wire waddr_t awaddr,
    input  wire [2:0]   awprot,  // Accepted, not decoded
    input  wire         awvalid,
    output logic        awready,
    input  wire word_t  wdata,
    input  wire strb_t  wstrb,
    input  wire         wvalid,
    output logic        wready,
    output resp_t       bresp,
    output logic        bvalid,
    input  wire         bready,
    output logic        wr_en,   // One-cycle register write strobe
    output waddr_t      wr_addr,
    output word_t       wr_data,
    output strb_t       wr_strb
);

    wr_state_t state_q;
    logic      accept; // Both beats taken this edge

    // Address and data are only taken together, never while a response waits
    assign accept  = (state_q == WR_IDLE) && awvalid && wvalid;
    assign awready = accept;
    assign wready  = accept;

    // Payload comes straight off the bus in the accept cycle
    assign wr_en   = accept;
    assign wr_addr = awaddr;
    assign wr_data = wdata;
    assign wr_strb = wstrb;

    assign bvalid = (state_q == WR_RESP);
    assign bresp  = RESP_OKAY; // No error responses

    always_ff @(posedge aclk) begin
        if (rst) begin
            state_q <= WR_IDLE;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    if (accept) begin
                        state_q <= WR_RESP; // Response out next cycle
                    end
                end
                WR_RESP: begin
                    if (bready) begin
                        state_q <= WR_IDLE; // Response taken
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    // A response, once offered, waits for the master
    a_bvalid_hold: assert property (@(posedge aclk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // No second write overtakes a pending response
    a_no_aw_while_b: assert property (@(posedge aclk) disable iff (rst)
        bvalid |-> !awready)
        else $error("awready high while bvalid pending");

endmodule

`default_nettype wire

/* hdl/gpio_input_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_input_sync import gpio_pkg::*; (
    input  wire        aclk,
    input  wire        rst,
    input  wire gpio_t gpio_io_i,
    input  wire gpio_t gpio2_io_i,
    output gpio_t      in1_sync,
    output gpio_t      in2_sync,
    output irq_bits_t  chg       // Registered change pulse per channel
);

    gpio_t pins   [2]; // Raw pins by channel
    gpio_t s1_q   [2]; // First sync flop that may go metastable
    gpio_t s2_q   [2]; // Second sync flop with a settled value
    gpio_t prev_q [2]; // Last seen synchronized value

    assign pins[0] = gpio_io_i;
    assign pins[1] = gpio2_io_i;

    // History flop trails the second sync flop by one cycle
    always_ff @(posedge aclk) begin
        for (int n = 0; n < 2; n++) begin
            s1_q[n]   <= pins[n];
            s2_q[n]   <= s1_q[n];
            prev_q[n] <= s2_q[n];
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            chg <= '0;
        end else begin
            for (int n = 0; n < 2; n++) begin
                chg[n] <= |(s2_q[n] ^ prev_q[n]); // Any bit moved
            end
        end
    end

    assign in1_sync = s2_q[0];
    assign in2_sync = s2_q[1];

endmodule

`default_nettype wire

/* hdl/gpio_irq.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_irq import gpio_pkg::*; (
    input  wire            aclk,
    input  wire            rst,
    input  wire            wr_en,
    input  wire waddr_t    wr_addr,
    input  wire word_t     wr_data,
    input  wire strb_t     wr_strb,
    input  wire irq_bits_t chg,   // Pin change pulses
    input  wire            gier,
    input  wire irq_bits_t ier,
    output irq_bits_t      isr,
    output logic           irq    // Registered, active high
);

    irq_bits_t isr_q;
    irq_bits_t toggle; // Bits written as 1 to the status word

    assign toggle = (wr_en && (wr_addr == ADDR_ISR) && wr_strb[0]) ? wr_data[1:0] : '0;

    always_ff @(posedge aclk) begin
        if (rst) begin
            isr_q <= '0;
            irq   <= 1'b0;
        end else begin
            // A change on the same edge beats a toggle
            isr_q <= chg | (isr_q ^ toggle);
            irq   <= gier & (|(isr_q & ier)); // Lags status by one cycle
        end
    end

    assign isr = isr_q;

    // Clearing the global enable silences irq from the next cycle on
    a_irq_gated: assert property (@(posedge aclk) disable iff (rst)
        !gier |=> !irq)
        else $error("irq high with global enable clear");

endmodule

`default_nettype wire

/* hdl/gpio_pkg.sv */
`default_nettype none

package gpio_pkg;

    // Bus side
    typedef logic [31:0] word_t;     // AXI data word
    typedef logic [3:0]  strb_t;     // One strobe per byte
    typedef logic [1:0]  resp_t;     // AXI response code
    typedef logic [8:2]  waddr_t;    // Word address from byte addr bits 8:2

    // Pin side
    typedef logic [31:0] gpio_t;     // One channel of pins
    typedef logic [1:0]  irq_bits_t; // Bit n for channel n+1

    // Word addresses of the register map
    localparam waddr_t ADDR_DATA1 = 7'h00; // 0x000
    localparam waddr_t ADDR_TRI1  = 7'h01; // 0x004
    localparam waddr_t ADDR_DATA2 = 7'h02; // 0x008
    localparam waddr_t ADDR_TRI2  = 7'h03; // 0x00C
    localparam waddr_t ADDR_GIER  = 7'h47; // 0x11C with enable in bit 31
    localparam waddr_t ADDR_ISR   = 7'h48; // 0x120 where a written 1 toggles
    localparam waddr_t ADDR_IER   = 7'h4A; // 0x128

    localparam resp_t RESP_OKAY = 2'b00; // Only response ever returned

    // Reset values of the channel registers
    localparam gpio_t DOUT_DEFAULT_1 = 32'h0000_0000;
    localparam gpio_t TRI_DEFAULT_1  = 32'hFFFF_FFFF; // All inputs
    localparam gpio_t DOUT_DEFAULT_2 = 32'h0000_0000;
    localparam gpio_t TRI_DEFAULT_2  = 32'hFFFF_FFFF; // All inputs

    // Write channel FSM
    typedef enum logic {
        WR_IDLE, // Waiting for address and data together
        WR_RESP  // Holding OKAY until bready
    } wr_state_t;

    // Read channel FSM
    typedef enum logic {
        RD_IDLE, // Waiting for arvalid
        RD_DATA  // Holding rdata until rready
    } rd_state_t;

endpackage

`default_nettype wire

/* hdl/gpio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_regs import gpio_pkg::*; (
    input  wire            aclk,
    input  wire            rst,
    input  wire            wr_en,
    input  wire waddr_t    wr_addr,
    input  wire word_t     wr_data,
    input  wire strb_t     wr_strb,
    input  wire waddr_t    rd_addr,
    input  wire gpio_t     in1_sync,
    input  wire gpio_t     in2_sync,
    input  wire irq_bits_t isr,        // Status, owned by gpio_irq
    output gpio_t          gpio_io_o,
    output gpio_t          gpio_io_t,
    output gpio_t          gpio2_io_o,
    output gpio_t          gpio2_io_t,
    output logic           gier,
    output irq_bits_t      ier,
    output word_t          rd_data     // Combinational read mux
);

    gpio_t     dout1_q; // Channel 1 output register
    gpio_t     tri1_q;  // Channel 1 direction, 1 = input
    gpio_t     dout2_q;
    gpio_t     tri2_q;
    logic      gier_q;  // Global interrupt enable
    irq_bits_t ier_q;   // Per-channel interrupt enable

    // Replace only the strobed bytes of a word
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Input bits read the pin and output bits read back the register
    function automatic word_t pin_view(input gpio_t pins, input gpio_t dout,
                                       input gpio_t dir);
        return (pins & dir) | (dout & ~dir);
    endfunction

    always_ff @(posedge aclk) begin
        if (rst) begin
            dout1_q <= DOUT_DEFAULT_1;
            tri1_q  <= TRI_DEFAULT_1;
            dout2_q <= DOUT_DEFAULT_2;
            tri2_q  <= TRI_DEFAULT_2;
            gier_q  <= 1'b0;
            ier_q   <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                ADDR_DATA1: dout1_q <= merge_bytes(dout1_q, wr_data, wr_strb);
                ADDR_TRI1:  tri1_q  <= merge_bytes(tri1_q, wr_data, wr_strb);
                ADDR_DATA2: dout2_q <= merge_bytes(dout2_q, wr_data, wr_strb);
                ADDR_TRI2:  tri2_q  <= merge_bytes(tri2_q, wr_data, wr_strb);
                ADDR_GIER: begin
                    if (wr_strb[3]) begin
                        gier_q <= wr_data[31]; // Lives in the top byte
                    end
                end
                ADDR_IER: begin
                    if (wr_strb[0]) begin
                        ier_q <= wr_data[1:0];
                    end
                end
                default: ; // ISR writes go to gpio_irq and others are dropped
            endcase
        end
    end

    // Read mux with unmapped words reading as zero
    always_comb begin
        case (rd_addr)
            ADDR_DATA1: rd_data = pin_view(in1_sync, dout1_q, tri1_q);
            ADDR_TRI1:  rd_data = tri1_q;
            ADDR_DATA2: rd_data = pin_view(in2_sync, dout2_q, tri2_q);
            ADDR_TRI2:  rd_data = tri2_q;
            ADDR_GIER:  rd_data = {gier_q, 31'd0};
            ADDR_ISR:   rd_data = {30'd0, isr};
            ADDR_IER:   rd_data = {30'd0, ier_q};
            default:    rd_data = '0;
        endcase
    end

    assign gpio_io_o  = dout1_q;
    assign gpio_io_t  = tri1_q;
    assign gpio2_io_o = dout2_q;
    assign gpio2_io_t = tri2_q;
    assign gier       = gier_q;
    assign ier        = ier_q;

endmodule

`default_nettype wire

/* tb/tb_axi_gpio.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_gpio import gpio_pkg::*; ();

    localparam int          N_OPS           = 400;  // Random operations
    localparam int          N_DIRECTED      = 20;   // Reset reads plus interrupt sequence
    localparam int          WATCHDOG_CYCLES = (N_OPS + N_DIRECTED) * 20 + 200;
    localparam logic [31:0] LFSR_SEED       = 32'he4f5_229c;
    localparam waddr_t      ADDR_SPARE      = 7'h7F; // Unmapped, used while stalling

    logic      aclk = 1'b0;
    logic      rst;
    waddr_t    awaddr;
    logic [2:0] awprot;
    logic      awvalid;
    logic      awready;
    word_t     wdata;
    strb_t     wstrb;
    logic      wvalid;
    logic      wready;
    resp_t     bresp;
    logic      bvalid;
    logic      bready;
    waddr_t    araddr;
    logic [2:0] arprot;
    logic      arvalid;
    logic      arready;
    word_t     rdata;
    resp_t     rresp;
    logic      rvalid;
    logic      rready;
    gpio_t     gpio_io_i;
    gpio_t     gpio_io_o;
    gpio_t     gpio_io_t;
    gpio_t     gpio2_io_i;
    gpio_t     gpio2_io_o;
    gpio_t     gpio2_io_t;
    logic      irq;

    // Register model
    gpio_t       m_dout [2];
    gpio_t       m_tri  [2];
    gpio_t       m_pins [2]; // Last value driven on the pins
    logic        m_gier;
    irq_bits_t   m_ier;
    irq_bits_t   m_isr;
    logic [31:0] lfsr = LFSR_SEED;

    axi_gpio_top dut (
        .aclk, .rst, .awaddr, .awprot, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready, .bresp, .bvalid, .bready,
        .araddr, .arprot, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .gpio_io_i, .gpio_io_o, .gpio_io_t, .gpio2_io_i, .gpio2_io_o, .gpio2_io_t, .irq
    );

    always #50 aclk = ~aclk; // 100 ns period

    // Taps 32, 22, 2 and 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t act, input word_t exp);
        if (act !== exp) begin
            abort_run($sformatf("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input resp_t act, input resp_t exp);
        if (act !== exp) begin
            abort_run($sformatf("FAIL at %0t ns: %s expected %b, got %b", $time, name, exp, act));
        end
    endtask

    task automatic check_gpio(input string name, input gpio_t act, input gpio_t exp);
        if (act !== exp) begin
            abort_run($sformatf("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_irq(input string name, input irq_bits_t act, input irq_bits_t exp);
        if (act !== exp) begin
            abort_run($sformatf("FAIL at %0t ns: %s expected %b, got %b", $time, name, exp, act));
        end
    endtask

    // Handshake bits
    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            abort_run($sformatf("FAIL at %0t ns: %s expected %b, got %b", $time, name, exp, act));
        end
    endtask

    function automatic void model_reset();
        m_dout[0] = DOUT_DEFAULT_1;
        m_dout[1] = DOUT_DEFAULT_2;
        m_tri[0]  = TRI_DEFAULT_1;
        m_tri[1]  = TRI_DEFAULT_2;
        m_gier    = 1'b0;
        m_ier     = '0;
        m_isr     = '0;
    endfunction

    function automatic void model_write(input waddr_t a, input word_t d, input strb_t s);
        word_t mask;
        mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}}; // Byte lanes to replace
        case (a)
            ADDR_DATA1: m_dout[0] = (m_dout[0] & ~mask) | (d & mask);
            ADDR_TRI1:  m_tri[0]  = (m_tri[0] & ~mask) | (d & mask);
            ADDR_DATA2: m_dout[1] = (m_dout[1] & ~mask) | (d & mask);
            ADDR_TRI2:  m_tri[1]  = (m_tri[1] & ~mask) | (d & mask);
            ADDR_GIER: begin
                if (s[3]) begin
                    m_gier = d[31];
                end
            end
            ADDR_ISR: begin
                if (s[0]) begin
                    m_isr = m_isr ^ d[1:0]; // Write 1 toggles
                end
            end
            ADDR_IER: begin
                if (s[0]) begin
                    m_ier = d[1:0];
                end
            end
            default: ;
        endcase
    endfunction

    // Tri bit 1 shows the pin and tri bit 0 the output register
    function automatic word_t data_view(input int ch);
        word_t w;
        for (int i = 0; i < 32; i++) begin
            w[i] = m_tri[ch][i] ? m_pins[ch][i] : m_dout[ch][i];
        end
        return w;
    endfunction

    function automatic word_t model_read(input waddr_t a);
        case (a)
            ADDR_DATA1: return data_view(0);
            ADDR_TRI1:  return m_tri[0];
            ADDR_DATA2: return data_view(1);
            ADDR_TRI2:  return m_tri[1];
            ADDR_GIER:  return {m_gier, 31'd0};
            ADDR_ISR:   return {30'd0, m_isr};
            ADDR_IER:   return {30'd0, m_ier};
            default:    return '0;
        endcase
    endfunction

    function automatic logic model_irq();
        logic hit;
        hit = (m_isr[0] && m_ier[0]) || (m_isr[1] && m_ier[1]); // Any enabled channel
        return m_gier && hit;
    endfunction

    // Mostly mapped words plus a few holes in the map
    function automatic waddr_t pick_addr();
        logic [3:0] sel;
        sel = 4'(rand_bits(4));
        case (sel)
            0, 1:    return ADDR_DATA1;
            2, 3:    return ADDR_TRI1;
            4, 5:    return ADDR_DATA2;
            6, 7:    return ADDR_TRI2;
            8:       return ADDR_GIER;
            9, 10:   return ADDR_ISR;
            11:      return ADDR_IER;
            12:      return 7'h04;
            13:      return 7'h46;
            14:      return 7'h49; // 0x124, between status and enable
            default: return ADDR_SPARE;
        endcase
    endfunction

    // Beats already valid; waits for accept, then holds bready low for gap cycles
    task automatic finish_write(input int gap);
        @(negedge aclk);
        while (!(awready && wready)) begin
            @(negedge aclk);
        end
        @(posedge aclk); // Both beats taken here
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge aclk);
        check_flag("bvalid", bvalid, 1'b1);
        check_resp("bresp", bresp, RESP_OKAY);
        for (int i = 0; i < gap; i++) begin
            @(posedge aclk);
            awaddr  <= ADDR_SPARE; // Next write waits behind the response
            wdata   <= '1;
            wstrb   <= '1;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            @(negedge aclk);
            check_flag("bvalid", bvalid, 1'b1);
            check_resp("bresp", bresp, RESP_OKAY);
            check_flag("awready", awready, 1'b0);
            check_flag("wready", wready, 1'b0);
        end
        @(posedge aclk);
        bready <= 1'b1;
        @(posedge aclk); // Response taken
        bready <= 1'b0;
    endtask

    task automatic axi_write(input waddr_t a, input word_t d, input strb_t s);
        int gap;
        gap = int'(rand_bits(2));
        @(posedge aclk);
        awaddr  <= a;
        awprot  <= 3'(rand_bits(3));
        wdata   <= d;
        wstrb   <= s;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        finish_write(gap);
        model_write(a, d, s);
        if (gap != 0) begin
            finish_write(0); // Queued write to the hole
        end
    endtask

    task automatic finish_read(input int gap, input word_t exp);
        @(negedge aclk);
        while (!arready) begin
            @(negedge aclk);
        end
        @(posedge aclk);
        arvalid <= 1'b0;
        @(negedge aclk);
        check_flag("rvalid", rvalid, 1'b1);
        check_resp("rresp", rresp, RESP_OKAY);
        check_word("rdata", rdata, exp);
        for (int i = 0; i < gap; i++) begin
            @(posedge aclk);
            araddr  <= ADDR_SPARE; // Next read waits behind the data
            arvalid <= 1'b1;
            @(negedge aclk);
            check_flag("rvalid", rvalid, 1'b1);
            check_word("rdata", rdata, exp);
            check_flag("arready", arready, 1'b0);
        end
        @(posedge aclk);
        rready <= 1'b1;
        @(posedge aclk);
        rready <= 1'b0;
    endtask

    task automatic axi_read(input waddr_t a, input word_t exp);
        int gap;
        gap = int'(rand_bits(2));
        @(posedge aclk);
        araddr  <= a;
        arprot  <= 3'(rand_bits(3));
        arvalid <= 1'b1;
        finish_read(gap, exp);
        if (gap != 0) begin
            finish_read(0, '0); // Hole reads as zero
        end
    endtask

    // Pins settle for 6 cycles before the model takes the change
    task automatic set_pins(input logic ch, input gpio_t v);
        @(posedge aclk);
        if (ch) begin
            gpio2_io_i <= v;
        end else begin
            gpio_io_i <= v;
        end
        repeat (6) @(posedge aclk);
        if (v != m_pins[ch]) begin
            m_isr[ch] = 1'b1;
        end
        m_pins[ch] = v;
    endtask

    task automatic check_state();
        @(negedge aclk);
        check_gpio("gpio_io_o", gpio_io_o, m_dout[0]);
        check_gpio("gpio_io_t", gpio_io_t, m_tri[0]);
        check_gpio("gpio2_io_o", gpio2_io_o, m_dout[1]);
        check_gpio("gpio2_io_t", gpio2_io_t, m_tri[1]);
        check_irq("irq", {1'b0, irq}, {1'b0, model_irq()});
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        abort_run($sformatf("Timeout after %0d cycles, a handshake never completed",
                            WATCHDOG_CYCLES));
    end

    initial begin
        logic [2:0] op;
        waddr_t     a;
        word_t      d;
        strb_t      s;
        rst        <= 1'b1;
        awaddr     <= '0;
        awprot     <= '0;
        awvalid    <= 1'b0;
        wdata      <= '0;
        wstrb      <= '0;
        wvalid     <= 1'b0;
        bready     <= 1'b0;
        araddr     <= '0;
        arprot     <= '0;
        arvalid    <= 1'b0;
        rready     <= 1'b0;
        gpio_io_i  <= '0;
        gpio2_io_i <= '0;
        m_pins[0]  = '0;
        m_pins[1]  = '0;
        model_reset();
        repeat (5) @(posedge aclk);
        rst <= 1'b0;

        check_state(); // Defaults on the pins and irq low
        axi_read(ADDR_DATA1, model_read(ADDR_DATA1));
        axi_read(ADDR_TRI1, model_read(ADDR_TRI1));
        axi_read(ADDR_DATA2, model_read(ADDR_DATA2));
        axi_read(ADDR_TRI2, model_read(ADDR_TRI2));
        axi_read(ADDR_GIER, model_read(ADDR_GIER));
        axi_read(ADDR_ISR, model_read(ADDR_ISR));
        axi_read(ADDR_IER, model_read(ADDR_IER));

        // Change on channel 1 with both enables set
        axi_write(ADDR_GIER, 32'h8000_0000, 4'b1000);
        axi_write(ADDR_IER, 32'h0000_0003, 4'b0001);
        set_pins(1'b0, 32'h0000_00A5);
        check_state();
        axi_read(ADDR_ISR, model_read(ADDR_ISR));
        axi_write(ADDR_ISR, 32'h0000_0001, 4'b0001); // Toggle clears it
        check_state();
        set_pins(1'b1, 32'h5A00_0000);
        check_state(); // irq raised by channel 2
        axi_write(ADDR_GIER, 32'h0000_0000, 4'b1000); // irq must drop
        check_state();

        for (int n = 0; n < N_OPS; n++) begin
            op = 3'(rand_bits(3));
            a  = pick_addr();
            d  = rand_bits(32);
            s  = 4'(rand_bits(4));
            if (op < 3) begin
                axi_write(a, d, s);
            end else if (op < 6) begin
                axi_read(a, model_read(a));
            end else begin
                set_pins(1'(rand_bits(1)), d);
            end
            check_state();
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
